// File: soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Bus widths
`define SOC_ALEN 32
`define SOC_XLEN 64

// SRAM depth in 64-bit words
`define SOC_SRAM_WORDS 512

`define SOC_GPIO_COUNT 4

// Values of addr[31:28] that select a device, all others are unmapped
`define SOC_REGION_SRAM 4'd1
`define SOC_REGION_PLAT 4'd2

`endif

// File: soc_pkg.sv
`default_nettype none

`include "soc_macros.svh"

package soc_pkg;

    // Host request, one per cycle with valid high
    typedef struct packed {
        logic                     valid;
        logic                     write;
        logic [`SOC_ALEN-1:0]     addr;
        logic [`SOC_XLEN-1:0]     wdata;
        logic [`SOC_XLEN/8-1:0]   wstrb;
    } bus_req_t;

    typedef enum logic [1:0] {
        DEV_NONE,
        DEV_SRAM,
        DEV_PLAT
    } dev_sel_t;

    // Request after stage 1, offset counts 64-bit words inside the region
    typedef struct packed {
        logic                     valid;
        dev_sel_t                 sel;
        logic                     write;
        logic [`SOC_ALEN-8:0]     offset;
        logic [`SOC_XLEN-1:0]     wdata;
        logic [`SOC_XLEN/8-1:0]   wstrb;
    } dec_req_t;

    typedef struct packed {
        logic                     valid;
        logic [`SOC_XLEN-1:0]     rdata;
    } dev_resp_t;

    typedef struct packed {
        logic                     valid;
        logic                     err;
        logic [`SOC_XLEN-1:0]     rdata;
    } bus_resp_t;

endpackage

`default_nettype wire

// File: bus_decode.sv
`default_nettype none

`include "soc_macros.svh"

module bus_decode (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire soc_pkg::bus_req_t  req,
    output soc_pkg::dec_req_t       dec
);

    logic [3:0]        region;
    soc_pkg::dev_sel_t region_sel;

    assign region = req.addr[`SOC_ALEN-1:`SOC_ALEN-4];

    always_comb begin
        case (region)
            `SOC_REGION_SRAM: region_sel = soc_pkg::DEV_SRAM;
            `SOC_REGION_PLAT: region_sel = soc_pkg::DEV_PLAT;
            // Unmapped, still sent down so the host gets an error response
            default:          region_sel = soc_pkg::DEV_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec.valid <= 1'b0;
            dec.sel   <= soc_pkg::DEV_NONE;
        end else begin
            dec.valid <= req.valid;
            dec.sel   <= region_sel;
        end
        dec.write  <= req.write;
        // Byte address to word offset, region bits dropped
        dec.offset <= req.addr[`SOC_ALEN-5:3];
        dec.wdata  <= req.wdata;
        dec.wstrb  <= req.wstrb;
    end

endmodule

`default_nettype wire

// File: sram_dev.sv
`default_nettype none

`include "soc_macros.svh"

module sram_dev (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire soc_pkg::dec_req_t  dec,
    output soc_pkg::dev_resp_t      resp
);

    localparam int IDX_W = $clog2(`SOC_SRAM_WORDS);

    logic [`SOC_XLEN-1:0] mem [`SOC_SRAM_WORDS];
    logic [IDX_W-1:0]     idx;
    logic                 hit;

    assign hit = dec.valid && (dec.sel == soc_pkg::DEV_SRAM);

    // Higher offset bits are ignored, so the array repeats across the region
    assign idx = dec.offset[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (hit && dec.write) begin
            for (int b = 0; b < `SOC_XLEN/8; b++) begin
                if (dec.wstrb[b]) begin
                    mem[idx][b*8 +: 8] <= dec.wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp.valid <= 1'b0;
        end else begin
            resp.valid <= hit;
        end
        // Writes answer with zero data
        if (dec.write) begin
            resp.rdata <= '0;
        end else begin
            resp.rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

// File: platform_dev.sv
`default_nettype none

`include "soc_macros.svh"

module platform_dev (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire soc_pkg::dec_req_t    dec,
    output soc_pkg::dev_resp_t        resp,
    output logic [`SOC_GPIO_COUNT-1:0] gpio,
    output logic                      mtime_int
);

    logic [`SOC_XLEN-1:0] mtime;
    logic [`SOC_XLEN-1:0] mtimecmp;
    logic [`SOC_XLEN-1:0] gpio_word;
    logic [`SOC_XLEN-1:0] gpio_next;
    logic                 hit;
    logic                 wr_en;
    logic                 wr_mtime;
    logic                 wr_mtimecmp;
    logic                 wr_gpio;

    // Keep old bytes where the strobe is clear
    function automatic logic [`SOC_XLEN-1:0] merge_bytes(
        input logic [`SOC_XLEN-1:0]   old_val,
        input logic [`SOC_XLEN-1:0]   new_val,
        input logic [`SOC_XLEN/8-1:0] strb
    );
        logic [`SOC_XLEN-1:0] result;
        result = old_val;
        for (int b = 0; b < `SOC_XLEN/8; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_val[b*8 +: 8];
            end
        end
        return result;
    endfunction

    assign hit         = dec.valid && (dec.sel == soc_pkg::DEV_PLAT);
    assign wr_en       = hit && dec.write;
    assign wr_mtime    = wr_en && (dec.offset == 'd0);
    assign wr_mtimecmp = wr_en && (dec.offset == 'd1);
    assign wr_gpio     = wr_en && (dec.offset == 'd2);

    assign gpio_word = `SOC_XLEN'(gpio);
    assign gpio_next = merge_bytes(gpio_word, dec.wdata, dec.wstrb);

    // Free-running timer, a write wins over the increment
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime <= '0;
        end else if (wr_mtime) begin
            mtime <= merge_bytes(mtime, dec.wdata, dec.wstrb);
        end else begin
            mtime <= mtime + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp <= '1;
        end else if (wr_mtimecmp) begin
            mtimecmp <= merge_bytes(mtimecmp, dec.wdata, dec.wstrb);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gpio <= '0;
        end else if (wr_gpio) begin
            gpio <= gpio_next[`SOC_GPIO_COUNT-1:0];
        end
    end

    // Level, stays high until the compare is moved past mtime
    assign mtime_int = (mtime >= mtimecmp);

    always_ff @(posedge clk) begin
        if (rst) begin
            resp.valid <= 1'b0;
        end else begin
            resp.valid <= hit;
        end
        if (dec.write) begin
            resp.rdata <= '0;
        end else begin
            case (dec.offset)
                'd0:     resp.rdata <= mtime;
                'd1:     resp.rdata <= mtimecmp;
                'd2:     resp.rdata <= gpio_word;
                default: resp.rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: resp_merge.sv
`default_nettype none

`include "soc_macros.svh"

module resp_merge (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire soc_pkg::dev_sel_t   sel,
    input  wire logic                stage_valid,
    input  wire soc_pkg::dev_resp_t  sram_resp,
    input  wire soc_pkg::dev_resp_t  plat_resp,
    output soc_pkg::bus_resp_t       resp
);

    logic                 merged_err;
    logic [`SOC_XLEN-1:0] merged_rdata;

    always_comb begin
        merged_err   = 1'b0;
        merged_rdata = '0;
        case (sel)
            soc_pkg::DEV_SRAM: begin
                merged_err   = !sram_resp.valid;
                merged_rdata = sram_resp.rdata;
            end
            soc_pkg::DEV_PLAT: begin
                merged_err   = !plat_resp.valid;
                merged_rdata = plat_resp.rdata;
            end
            default: begin
                merged_err = 1'b1;
            end
        endcase
        // No data alongside an error
        if (merged_err) begin
            merged_rdata = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp.valid <= 1'b0;
            resp.err   <= 1'b0;
        end else begin
            resp.valid <= stage_valid;
            resp.err   <= stage_valid && merged_err;
        end
        resp.rdata <= merged_rdata;
    end

endmodule

`default_nettype wire

// File: soc_lite.sv
`default_nettype none

`include "soc_macros.svh"

module soc_lite (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire soc_pkg::bus_req_t    req,
    output soc_pkg::bus_resp_t        resp,
    output logic [`SOC_GPIO_COUNT-1:0] gpio,
    output logic                      mtime_int
);

    soc_pkg::dec_req_t  dec;
    soc_pkg::dev_resp_t sram_resp;
    soc_pkg::dev_resp_t plat_resp;
    soc_pkg::dev_sel_t  s2_sel;
    logic               s2_valid;

    bus_decode u_bus_decode (
        .clk (clk),
        .rst (rst),
        .req (req),
        .dec (dec)
    );

    // Selector follows the request through the device stage
    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
            s2_sel   <= soc_pkg::DEV_NONE;
        end else begin
            s2_valid <= dec.valid;
            s2_sel   <= dec.sel;
        end
    end

    sram_dev u_sram_dev (
        .clk  (clk),
        .rst  (rst),
        .dec  (dec),
        .resp (sram_resp)
    );

    platform_dev u_platform_dev (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec),
        .resp      (plat_resp),
        .gpio      (gpio),
        .mtime_int (mtime_int)
    );

    resp_merge u_resp_merge (
        .clk         (clk),
        .rst         (rst),
        .sel         (s2_sel),
        .stage_valid (s2_valid),
        .sram_resp   (sram_resp),
        .plat_resp   (plat_resp),
        .resp        (resp)
    );

endmodule

`default_nettype wire

// File: tb_soc_table.svh
// Columns: test number, operation, byte address, write data, byte strobes, expected read data
typedef struct packed {
    logic [3:0]  test;
    logic [2:0]  op;
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [7:0]  wstrb;
    logic [63:0] want;
} row_t;

// Operations
localparam logic [2:0] OP_WR   = 3'd0;
localparam logic [2:0] OP_WRND = 3'd1;
localparam logic [2:0] OP_RDS  = 3'd2;
localparam logic [2:0] OP_RD   = 3'd3;
localparam logic [2:0] OP_GPIO = 3'd4;

row_t rows [$];

task automatic add_row(input int test, input logic [2:0] op, input logic [31:0] addr,
                       input logic [63:0] wdata, input logic [7:0] wstrb,
                       input logic [63:0] want);
    rows.push_back({4'(test), op, addr, wdata, wstrb, want});
endtask

task automatic build_table();
    // Full words first, so later partial writes never leave unknown bytes
    add_row(2, OP_WRND, 32'h1000_0000, '0, 8'hff, '0);
    add_row(2, OP_WRND, 32'h1000_0008, '0, 8'hff, '0);
    add_row(2, OP_WRND, 32'h1000_0010, '0, 8'hff, '0);
    add_row(2, OP_WRND, 32'h1000_0018, '0, 8'hff, '0);
    add_row(2, OP_WRND, 32'h1000_0ff8, '0, 8'hff, '0);
    add_row(2, OP_WRND, 32'h1000_0008, '0, 8'h0f, '0);
    add_row(2, OP_WRND, 32'h1000_0010, '0, 8'ha5, '0);
    add_row(2, OP_WRND, 32'h1000_0ff8, '0, 8'h3c, '0);
    // Offset 0x203 lands on word 3
    add_row(2, OP_WRND, 32'h1000_1018, '0, 8'hc3, '0);
    add_row(2, OP_RDS,  32'h1000_0000, '0, 8'h00, '0);
    add_row(2, OP_RDS,  32'h1000_0008, '0, 8'h00, '0);
    add_row(2, OP_RDS,  32'h1000_0010, '0, 8'h00, '0);
    add_row(2, OP_RDS,  32'h1000_0018, '0, 8'h00, '0);
    add_row(2, OP_RDS,  32'h1000_2018, '0, 8'h00, '0);
    add_row(2, OP_RDS,  32'h1000_0ff8, '0, 8'h00, '0);
    add_row(2, OP_RDS,  32'h1000_1ff8, '0, 8'h00, '0);
    add_row(3, OP_RDS,  32'h1000_0ff8, '0, 8'h00, '0);
    add_row(3, OP_RDS,  32'h1000_0000, '0, 8'h00, '0);
    add_row(3, OP_RDS,  32'h1000_0018, '0, 8'h00, '0);
    add_row(3, OP_RDS,  32'h1000_0008, '0, 8'h00, '0);
    add_row(3, OP_RDS,  32'h1000_0010, '0, 8'h00, '0);
    add_row(4, OP_WR,   32'h0000_0008, 64'hdead_beef_0bad_f00d, 8'hff, '0);
    add_row(4, OP_WR,   32'h3000_0010, 64'h0123_4567_89ab_cdef, 8'hff, '0);
    add_row(4, OP_RD,   32'hf000_0000, '0, 8'h00, '0);
    add_row(4, OP_RDS,  32'h1000_0008, '0, 8'h00, '0);
    add_row(4, OP_RD,   32'h2000_0010, '0, 8'h00, '0);
    add_row(5, OP_WR,   32'h2000_0010, 64'h5, 8'hff, '0);
    add_row(5, OP_GPIO, '0, '0, 8'h00, 64'h5);
    add_row(5, OP_RD,   32'h2000_0010, '0, 8'h00, 64'h5);
    add_row(5, OP_WR,   32'h2000_0010, 64'hffff_ffff_ffff_fffa, 8'h01, '0);
    add_row(5, OP_GPIO, '0, '0, 8'h00, 64'ha);
    add_row(5, OP_RD,   32'h2000_0010, '0, 8'h00, 64'ha);
    // Lane 1 only, GPIO bits sit in lane 0
    add_row(5, OP_WR,   32'h2000_0010, 64'h3, 8'h02, '0);
    add_row(5, OP_GPIO, '0, '0, 8'h00, 64'ha);
    add_row(5, OP_RD,   32'h2000_0018, '0, 8'h00, '0);
endtask

// File: tb_soc_lite.sv
`default_nettype none

`include "soc_macros.svh"

module tb_soc_lite;

    typedef struct packed {
        logic        check_data;
        logic        err;
        logic [63:0] rdata;
        logic [31:0] cycle;
    } exp_t;

    localparam logic [63:0] TIMER_START = 64'h0000_0001_0000_0000;

    logic                       clk = 1'b0;
    logic                       rst = 1'b1;
    soc_pkg::bus_req_t          req;
    soc_pkg::bus_resp_t         resp;
    logic [`SOC_GPIO_COUNT-1:0] gpio;
    logic                       mtime_int;

    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count  = 0;
    logic [31:0] lfsr = 32'd79812;
    logic [63:0] shadow [`SOC_SRAM_WORDS];
    exp_t        exp_q [$];
    logic [63:0] got_q [$];
    exp_t        head;

    `include "tb_soc_table.svh"

    soc_lite u_soc_lite (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .resp      (resp),
        .gpio      (gpio),
        .mtime_int (mtime_int)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want);
        check_count++;
        if (got !== want) begin
            $display("ERR %s got %h expected %h", name, got, want);
            error_count++;
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'hb4bc_d35c;
        end else begin
            return state >> 1;
        end
    endfunction

    task automatic draw_random(input int nbits, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);
            value[i] = lfsr[0];
        end
    endtask

    function automatic logic is_unmapped(input logic [31:0] addr);
        return addr[31:28] != `SOC_REGION_SRAM && addr[31:28] != `SOC_REGION_PLAT;
    endfunction

    function automatic int shadow_index(input logic [31:0] addr);
        return int'((addr[27:0] >> 3) % `SOC_SRAM_WORDS);
    endfunction

    task automatic shadow_write(input logic [31:0] addr, input logic [63:0] data,
                                input logic [7:0] strb);
        int idx;
        idx = shadow_index(addr);
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                shadow[idx][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    task automatic issue(input logic write, input logic [31:0] addr, input logic [63:0] wdata,
                         input logic [7:0] wstrb, input logic check_data,
                         input logic [63:0] rdata);
        exp_t e;
        @(negedge clk);
        req = '{valid: 1'b1, write: write, addr: addr, wdata: wdata, wstrb: wstrb};
        e.check_data = check_data;
        e.err        = is_unmapped(addr);
        e.rdata      = (write || e.err) ? '0 : rdata;
        e.cycle      = cycle_count;
        exp_q.push_back(e);
    endtask

    task automatic go_idle();
        @(negedge clk);
        req = '0;
    endtask

    task automatic drain();
        while (exp_q.size() > 0) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    function automatic string test_name(input int num);
        case (num)
            2:       return "sram data";
            3:       return "back-to-back reads";
            4:       return "unmapped access";
            default: return "gpio";
        endcase
    endfunction

    task automatic report_test(input int num, input string name, input int errs_before);
        test_count++;
        $display("test %0d %s: %s", num, name, (error_count == errs_before) ? "ok" : "failed");
    endtask

    task automatic run_reset_test();
        int errs_before;
        errs_before = error_count;
        repeat (10) begin
            @(negedge clk);
            compare("resp.valid", resp.valid, 1'b0);
            compare("gpio", gpio, '0);
            compare("mtime_int", mtime_int, 1'b0);
        end
        report_test(1, "reset state", errs_before);
    endtask

    task automatic run_timer_test();
        int          errs_before;
        int unsigned start;
        logic [63:0] first;
        logic [63:0] second;
        errs_before = error_count;
        issue(1'b1, 32'h2000_0000, TIMER_START, 8'hff, 1'b1, '0);
        issue(1'b1, 32'h2000_0008, TIMER_START + 200, 8'hff, 1'b1, '0);
        start = cycle_count;
        go_idle();
        drain();
        compare("mtime_int", mtime_int, 1'b0);
        while (!mtime_int && (cycle_count - start) < 260) begin
            @(negedge clk);
        end
        if (!mtime_int) begin
            $display("mtime_int did not rise within 260 cycles of the compare write");
            error_count++;
        end
        issue(1'b0, 32'h2000_0000, '0, '0, 1'b0, '0);
        issue(1'b0, 32'h2000_0000, '0, '0, 1'b0, '0);
        go_idle();
        drain();
        if (got_q.size() != 2) begin
            $display("expected two mtime reads but captured %0d", got_q.size());
            error_count++;
        end else begin
            first  = got_q.pop_front();
            second = got_q.pop_front();
            if (first < TIMER_START || second <= first) begin
                $display("mtime reads %h then %h do not increase from the start value",
                         first, second);
                error_count++;
            end
        end
        issue(1'b1, 32'h2000_0008, '1, 8'hff, 1'b1, '0);
        go_idle();
        drain();
        compare("mtime_int", mtime_int, 1'b0);
        report_test(6, "machine timer", errs_before);
    endtask

    // Response monitor, matched in order against issued requests
    always @(negedge clk) begin
        if (!rst && resp.valid) begin
            if (exp_q.size() == 0) begin
                $display("response arrived with no request outstanding");
                error_count++;
            end else begin
                head = exp_q.pop_front();
                compare("latency", cycle_count - head.cycle, 64'd3);
                compare("resp.err", resp.err, head.err);
                if (head.check_data) begin
                    compare("resp.rdata", resp.rdata, head.rdata);
                end else begin
                    got_q.push_back(resp.rdata);
                end
            end
        end
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
        end
        $display("timeout after %0d cycles, run stopped", cycle_count);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        row_t        r;
        logic [63:0] data;
        int          cur_test;
        int          errs_before;
        req = '0;
        build_table();
        cycle_limit = rows.size() * 8 + 2000;
        repeat (16) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst = 1'b0;
        run_reset_test();
        cur_test    = rows[0].test;
        errs_before = error_count;
        foreach (rows[i]) begin
            r = rows[i];
            if (r.test != cur_test) begin
                go_idle();
                drain();
                report_test(cur_test, test_name(cur_test), errs_before);
                cur_test    = r.test;
                errs_before = error_count;
            end
            case (r.op)
                OP_WR, OP_WRND: begin
                    if (r.op == OP_WRND) begin
                        draw_random(64, data);
                    end else begin
                        data = r.wdata;
                    end
                    if (r.addr[31:28] == `SOC_REGION_SRAM) begin
                        shadow_write(r.addr, data, r.wstrb);
                    end
                    issue(1'b1, r.addr, data, r.wstrb, 1'b1, '0);
                end
                OP_RDS: issue(1'b0, r.addr, '0, '0, 1'b1, shadow[shadow_index(r.addr)]);
                OP_RD:  issue(1'b0, r.addr, '0, '0, 1'b1, r.want);
                default: begin
                    go_idle();
                    drain();
                    compare("gpio", gpio, r.want);
                end
            endcase
        end
        go_idle();
        drain();
        report_test(cur_test, test_name(cur_test), errs_before);
        run_timer_test();
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
soc_pkg.sv
bus_decode.sv
sram_dev.sv
platform_dev.sv
resp_merge.sv
soc_lite.sv
tb_soc_lite.sv
